// ==== Makefile ====
TOP := core_tb
LOG := sim.log

.PHONY: all sim lint clean

all: sim

obj_dir/V$(TOP): flist.f hw/*.sv hw/*.svh verification/*.sv
	verilator --binary --assert -j 0 --top-module $(TOP) -f flist.f -o V$(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "All tests passed" $(LOG) || (echo "Simulation did not finish"; exit 1)

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir $(LOG)

// ==== flist.f ====
+incdir+hw
hw/core_pkg.sv
hw/core_apb_port.sv
hw/instr_decode.sv
hw/reg_file.sv
hw/alu_execute.sv
hw/result_writeback.sv
hw/core_top.sv
verification/core_tb.sv

// ==== hw/alu_execute.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module alu_execute (
	input  core_pkg::exe_op_t exe_op,
	output core_pkg::wb_op_t  exe_result
);
	import core_pkg::*;

	word_t                       a;
	word_t                       b;
	logic [3:0]                  shamt;
	logic [`CORE_DATA_W:0]       sum;
	logic [2*`CORE_DATA_W-1:0]   rot_l;
	logic [2*`CORE_DATA_W-1:0]   rot_r;
	logic                        equal;
	logic                        signed_lt;
	word_t                       result;

	assign a = exe_op.a;
	assign b = exe_op.b;

	// Shift amount from imm5 or Rt, low four bits either way
	assign shamt = b[3:0];

	// Extra bit keeps the carry for SCO
	assign sum = {1'b0, a} + {1'b0, b};

	// Rotates on a doubled word
	assign rot_l = {a, a} << shamt;
	assign rot_r = {a, a} >> shamt;

	assign equal = (a == b);
	assign signed_lt = ($signed(a) < $signed(b));

	always_comb begin
		result = '0;
		case (exe_op.alu_op)
			ALU_ADD: result = sum[`CORE_DATA_W-1:0];
			// Reversed operand order, second minus first
			ALU_SUB: result = b - a;
			ALU_XOR: result = a ^ b;
			ALU_ANDN: result = a & ~b;
			ALU_ROL: result = rot_l[2*`CORE_DATA_W-1:`CORE_DATA_W];
			ALU_SLL: result = a << shamt;
			ALU_ROR: result = rot_r[`CORE_DATA_W-1:0];
			ALU_SRL: result = a >> shamt;
			ALU_SEQ: result = word_t'(equal);
			ALU_SLT: result = word_t'(signed_lt);
			ALU_SLE: result = word_t'(signed_lt | equal);
			ALU_SCO: result = word_t'(sum[`CORE_DATA_W]);
			ALU_BTR: result = {<<{a}};
			ALU_PASS_B: result = b;
			// Old low byte moves up, imm8 fills the bottom
			ALU_SLBI: result = {a[7:0], b[7:0]};
			default: result = '0;
		endcase
	end

	assign exe_result.valid = exe_op.valid;
	assign exe_result.rd = exe_op.rd;
	assign exe_result.data = result;

endmodule

// ==== hw/core_apb_port.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module core_apb_port (
	input  logic               clk,
	input  logic               rst_n,
	input  core_pkg::apb_req_t apb_req,
	output core_pkg::apb_rsp_t apb_rsp,
	output core_pkg::word_t    instr_word,
	output logic               instr_issue,
	input  logic               instr_illegal,
	input  logic               exe_valid,
	input  logic               wb_valid,
	output core_pkg::reg_idx_t host_idx,
	input  core_pkg::word_t    host_data
);
	logic                        access;
	logic                        hit_instr;
	logic                        hit_reg;
	logic [`CORE_APB_ADDR_W-1:0] reg_off;
	logic                        drained;
	logic                        bad_access;

	assign access = apb_req.psel & apb_req.penable;

	// Address decode
	assign hit_instr = (apb_req.paddr == `CORE_ADDR_INSTR);
	assign reg_off = apb_req.paddr - `CORE_ADDR_REG_BASE;
	// Below the base wraps to a large offset and misses
	assign hit_reg = (reg_off < 8'(4 * `CORE_REG_CNT)) && (reg_off[1:0] == 2'b00);
	assign host_idx = reg_off[2 +: `CORE_REG_ADDR_W];

	// Nothing left in execute or result stage
	assign drained = ~exe_valid & ~wb_valid;

	// Writes never wait, so access phase is the completing cycle
	assign instr_word = apb_req.pwdata;
	assign instr_issue = access & apb_req.pwrite & hit_instr;

	assign bad_access = apb_req.pwrite ? (~hit_instr | instr_illegal) : ~hit_reg;

	// Only a register read holds off, until the pipeline drains
	assign apb_rsp.pready = access & (apb_req.pwrite | ~hit_reg | drained);
	assign apb_rsp.pslverr = access & bad_access;
	assign apb_rsp.prdata = (apb_rsp.pready & ~apb_req.pwrite & hit_reg) ? host_data : '0;

	a_penable_needs_psel: assert property (
		@(posedge clk) disable iff (!rst_n)
		apb_req.penable |-> apb_req.psel
	);

endmodule

// ==== hw/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Datapath and register file
`define CORE_DATA_W 16
`define CORE_REG_CNT 8
`define CORE_REG_ADDR_W 3

// APB address map
`define CORE_APB_ADDR_W 8
`define CORE_ADDR_INSTR 8'h00
// Register r sits at base + 4*r
`define CORE_ADDR_REG_BASE 8'h20

`endif

// ==== hw/core_pkg.sv ====
`include "core_config.svh"

package core_pkg;

	typedef logic [`CORE_DATA_W-1:0] word_t;
	typedef logic [`CORE_REG_ADDR_W-1:0] reg_idx_t;

	// Instruction bits 15..11
	typedef enum logic [4:0] {
		OP_NOP     = 5'b00001,
		OP_ADDI    = 5'b01000,
		OP_SUBI    = 5'b01001,
		OP_XORI    = 5'b01010,
		OP_ANDNI   = 5'b01011,
		OP_ROLI    = 5'b10100,
		OP_SLLI    = 5'b10101,
		OP_RORI    = 5'b10110,
		OP_SRLI    = 5'b10111,
		OP_SLBI    = 5'b10010,
		OP_LBI     = 5'b11000,
		OP_BTR     = 5'b11001,
		OP_SHIFT_R = 5'b11010,
		OP_ALU_R   = 5'b11011,
		OP_SEQ     = 5'b11100,
		OP_SLT     = 5'b11101,
		OP_SLE     = 5'b11110,
		OP_SCO     = 5'b11111
	} opcode_e;

	// Groups of four line up with opcode/funct low bits
	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_XOR    = 4'd2,
		ALU_ANDN   = 4'd3,
		ALU_ROL    = 4'd4,
		ALU_SLL    = 4'd5,
		ALU_ROR    = 4'd6,
		ALU_SRL    = 4'd7,
		ALU_SEQ    = 4'd8,
		ALU_SLT    = 4'd9,
		ALU_SLE    = 4'd10,
		ALU_SCO    = 4'd11,
		ALU_BTR    = 4'd12,
		ALU_PASS_B = 4'd13,
		ALU_SLBI   = 4'd14
	} alu_op_e;

	typedef struct packed {
		logic     valid;
		alu_op_e  alu_op;
		word_t    a;
		word_t    b;
		reg_idx_t rd;
	} exe_op_t;

	// Result leaving execute, also the write-back item
	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		word_t    data;
	} wb_op_t;

	typedef struct packed {
		logic                        psel;
		logic                        penable;
		logic                        pwrite;
		logic [`CORE_APB_ADDR_W-1:0] paddr;
		word_t                       pwdata;
	} apb_req_t;

	typedef struct packed {
		word_t prdata;
		logic  pready;
		logic  pslverr;
	} apb_rsp_t;

endpackage

// ==== hw/core_top.sv ====
`timescale 1ns/1ps

module core_top (
	input  logic               clk,
	input  logic               rst_n,
	input  core_pkg::apb_req_t apb_req,
	output core_pkg::apb_rsp_t apb_rsp
);
	import core_pkg::*;

	word_t    instr_word;
	logic     instr_issue;
	logic     instr_illegal;
	reg_idx_t host_idx;
	word_t    host_data;
	reg_idx_t rs_idx;
	reg_idx_t rt_idx;
	word_t    rs_data;
	word_t    rt_data;
	exe_op_t  exe_op;
	wb_op_t   exe_result;
	wb_op_t   wb_op;

	// Host side
	core_apb_port u_apb_port (
		.clk,
		.rst_n,
		.apb_req,
		.apb_rsp,
		.instr_word,
		.instr_issue,
		.instr_illegal,
		.exe_valid (exe_op.valid),
		.wb_valid  (wb_op.valid),
		.host_idx,
		.host_data
	);

	// Decode stage
	instr_decode u_decode (
		.clk,
		.rst_n,
		.instr_word,
		.instr_issue,
		.instr_illegal,
		.rs_idx,
		.rt_idx,
		.rs_data,
		.rt_data,
		.exe_result,
		.wb_op,
		.exe_op
	);

	reg_file u_reg_file (
		.clk,
		.rst_n,
		.rs_idx,
		.rt_idx,
		.host_idx,
		.rs_data,
		.rt_data,
		.host_data,
		.wb_op
	);

	// Execute stage
	alu_execute u_execute (
		.exe_op,
		.exe_result
	);

	// Result stage
	result_writeback u_writeback (
		.clk,
		.rst_n,
		.exe_result,
		.wb_op
	);

endmodule

// ==== hw/instr_decode.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module instr_decode (
	input  logic               clk,
	input  logic               rst_n,
	input  core_pkg::word_t    instr_word,
	input  logic               instr_issue,
	output logic               instr_illegal,
	output core_pkg::reg_idx_t rs_idx,
	output core_pkg::reg_idx_t rt_idx,
	input  core_pkg::word_t    rs_data,
	input  core_pkg::word_t    rt_data,
	input  core_pkg::wb_op_t   exe_result,
	input  core_pkg::wb_op_t   wb_op,
	output core_pkg::exe_op_t  exe_op
);
	import core_pkg::*;

	opcode_e    opcode;
	logic [1:0] funct;
	word_t      imm5_sext;
	word_t      imm5_zext;
	word_t      imm8_sext;
	word_t      imm8_zext;
	word_t      rs_fwd;
	word_t      rt_fwd;
	alu_op_e    alu_op;
	word_t      op_b;
	reg_idx_t   rd_idx;
	logic       legal;
	logic       is_nop;

	// Youngest result first, then result stage, then register file
	function automatic word_t fwd_operand(reg_idx_t idx, word_t rf_data, wb_op_t ex, wb_op_t wb);
		if (ex.valid && ex.rd == idx) begin
			return ex.data;
		end
		if (wb.valid && wb.rd == idx) begin
			return wb.data;
		end
		return rf_data;
	endfunction

	assign opcode = opcode_e'(instr_word[15:11]);
	assign funct = instr_word[1:0];
	assign rs_idx = instr_word[10:8];
	assign rt_idx = instr_word[7:5];

	assign imm5_sext = {{(`CORE_DATA_W-5){instr_word[4]}}, instr_word[4:0]};
	assign imm5_zext = {{(`CORE_DATA_W-5){1'b0}}, instr_word[4:0]};
	assign imm8_sext = {{(`CORE_DATA_W-8){instr_word[7]}}, instr_word[7:0]};
	assign imm8_zext = {{(`CORE_DATA_W-8){1'b0}}, instr_word[7:0]};

	assign rs_fwd = fwd_operand(rs_idx, rs_data, exe_result, wb_op);
	assign rt_fwd = fwd_operand(rt_idx, rt_data, exe_result, wb_op);

	// Low opcode or funct bits pick the op within each group of four
	always_comb begin
		alu_op = ALU_PASS_B;
		op_b = rt_fwd;
		rd_idx = instr_word[7:5];
		legal = 1'b1;
		is_nop = 1'b0;
		case (opcode)
			OP_NOP: is_nop = 1'b1;
			OP_ADDI, OP_SUBI: begin
				alu_op = alu_op_e'({2'b00, instr_word[12:11]});
				op_b = imm5_sext;
			end
			OP_XORI, OP_ANDNI: begin
				alu_op = alu_op_e'({2'b00, instr_word[12:11]});
				op_b = imm5_zext;
			end
			OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
				alu_op = alu_op_e'({2'b01, instr_word[12:11]});
				op_b = imm5_zext;
			end
			OP_LBI: begin
				op_b = imm8_sext;
				rd_idx = rs_idx;
			end
			OP_SLBI: begin
				alu_op = ALU_SLBI;
				op_b = imm8_zext;
				rd_idx = rs_idx;
			end
			OP_BTR: begin
				alu_op = ALU_BTR;
				rd_idx = instr_word[4:2];
			end
			OP_ALU_R: begin
				alu_op = alu_op_e'({2'b00, funct});
				rd_idx = instr_word[4:2];
			end
			OP_SHIFT_R: begin
				alu_op = alu_op_e'({2'b01, funct});
				rd_idx = instr_word[4:2];
			end
			OP_SEQ, OP_SLT, OP_SLE, OP_SCO: begin
				alu_op = alu_op_e'({2'b10, instr_word[12:11]});
				rd_idx = instr_word[4:2];
			end
			default: legal = 1'b0;
		endcase
	end

	assign instr_illegal = ~legal;

	// Decode to execute register
	always_ff @(posedge clk) begin
		if (instr_issue) begin
			exe_op.alu_op <= alu_op;
			exe_op.a <= rs_fwd;
			exe_op.b <= op_b;
			exe_op.rd <= rd_idx;
		end
		if (!rst_n) begin
			exe_op.valid <= 1'b0;
		end else begin
			exe_op.valid <= instr_issue & legal & ~is_nop;
		end
	end

	a_known_alu_op: assert property (
		@(posedge clk) disable iff (!rst_n)
		exe_op.valid |-> (!$isunknown(exe_op.alu_op) && exe_op.alu_op <= ALU_SLBI)
	);

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module reg_file (
	input  logic               clk,
	input  logic               rst_n,
	input  core_pkg::reg_idx_t rs_idx,
	input  core_pkg::reg_idx_t rt_idx,
	input  core_pkg::reg_idx_t host_idx,
	output core_pkg::word_t    rs_data,
	output core_pkg::word_t    rt_data,
	output core_pkg::word_t    host_data,
	input  core_pkg::wb_op_t   wb_op
);
	import core_pkg::*;

	word_t regs [`CORE_REG_CNT];

	// Architectural state, cleared so reads after reset return zero
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `CORE_REG_CNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_op.valid) begin
			regs[wb_op.rd] <= wb_op.data;
		end
	end

	// Two operand ports for decode
	assign rs_data = regs[rs_idx];
	assign rt_data = regs[rt_idx];

	// Host read-back port
	assign host_data = regs[host_idx];

endmodule

// ==== hw/result_writeback.sv ====
`timescale 1ns/1ps

module result_writeback (
	input  logic             clk,
	input  logic             rst_n,
	input  core_pkg::wb_op_t exe_result,
	output core_pkg::wb_op_t wb_op
);

	// Execute to result register, feeds the register file write
	// and the older forwarding path in decode
	always_ff @(posedge clk) begin
		wb_op.rd <= exe_result.rd;
		wb_op.data <= exe_result.data;
		if (!rst_n) begin
			wb_op.valid <= 1'b0;
		end else begin
			wb_op.valid <= exe_result.valid;
		end
	end

	a_wb_data_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		wb_op.valid |-> !$isunknown(wb_op.data)
	);

endmodule

// ==== verification/core_tb.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module core_tb;
	import core_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int WAIT_LIMIT = 50;

	logic     clk;
	logic     rst_n;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	word_t    model [`CORE_REG_CNT];
	int       seed;
	int       errors;
	int       checks;

	core_top u_dut (
		.clk,
		.rst_n,
		.apb_req,
		.apb_rsp
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_err(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
		end
	endtask

	// Instruction encodings for I-format, R-format and byte-immediate
	function automatic word_t enc_i(logic [4:0] op, reg_idx_t rs, reg_idx_t rd, logic [4:0] imm);
		return {op, rs, rd, imm};
	endfunction

	function automatic word_t enc_r(logic [4:0] op, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd,
			logic [1:0] funct);
		return {op, rs, rt, rd, funct};
	endfunction

	function automatic word_t enc_b(logic [4:0] op, reg_idx_t rs, logic [7:0] imm);
		return {op, rs, imm};
	endfunction

	function automatic logic [`CORE_APB_ADDR_W-1:0] reg_addr(int r);
		return `CORE_ADDR_REG_BASE + {r[`CORE_APB_ADDR_W-3:0], 2'b00};
	endfunction

	function automatic word_t rotl(word_t x, logic [3:0] n);
		return (x << n) | (x >> (`CORE_DATA_W - n));
	endfunction

	function automatic word_t rotr(word_t x, logic [3:0] n);
		return (x >> n) | (x << (`CORE_DATA_W - n));
	endfunction

	function automatic word_t reverse_bits(word_t x);
		word_t r;
		for (int i = 0; i < `CORE_DATA_W; i++) begin
			r[i] = x[`CORE_DATA_W-1-i];
		end
		return r;
	endfunction

	// Reference model of the register file that returns 0 for an illegal opcode
	function automatic logic model_exec(word_t instr);
		logic [4:0] op;
		reg_idx_t   rs;
		reg_idx_t   rd_i;
		reg_idx_t   rd_r;
		word_t      s5;
		word_t      z5;
		word_t      vs;
		word_t      vt;
		op = instr[15:11];
		rs = instr[10:8];
		rd_i = instr[7:5];
		rd_r = instr[4:2];
		s5 = {{(`CORE_DATA_W-5){instr[4]}}, instr[4:0]};
		z5 = {{(`CORE_DATA_W-5){1'b0}}, instr[4:0]};
		vs = model[rs];
		vt = model[instr[7:5]];
		case (op)
			OP_NOP: begin
			end
			OP_ADDI: model[rd_i] = vs + s5;
			OP_SUBI: model[rd_i] = s5 - vs;
			OP_XORI: model[rd_i] = vs ^ z5;
			OP_ANDNI: model[rd_i] = vs & ~z5;
			OP_ROLI: model[rd_i] = rotl(vs, instr[3:0]);
			OP_SLLI: model[rd_i] = vs << instr[3:0];
			OP_RORI: model[rd_i] = rotr(vs, instr[3:0]);
			OP_SRLI: model[rd_i] = vs >> instr[3:0];
			OP_LBI: model[rs] = {{(`CORE_DATA_W-8){instr[7]}}, instr[7:0]};
			OP_SLBI: model[rs] = (vs << 8) | {{(`CORE_DATA_W-8){1'b0}}, instr[7:0]};
			OP_BTR: model[rd_r] = reverse_bits(vs);
			OP_ALU_R: begin
				case (instr[1:0])
					2'd0: model[rd_r] = vs + vt;
					2'd1: model[rd_r] = vt - vs;
					2'd2: model[rd_r] = vs ^ vt;
					default: model[rd_r] = vs & ~vt;
				endcase
			end
			OP_SHIFT_R: begin
				case (instr[1:0])
					2'd0: model[rd_r] = rotl(vs, vt[3:0]);
					2'd1: model[rd_r] = vs << vt[3:0];
					2'd2: model[rd_r] = rotr(vs, vt[3:0]);
					default: model[rd_r] = vs >> vt[3:0];
				endcase
			end
			OP_SEQ: model[rd_r] = word_t'(vs == vt);
			OP_SLT: model[rd_r] = word_t'($signed(vs) < $signed(vt));
			OP_SLE: model[rd_r] = word_t'($signed(vs) <= $signed(vt));
			OP_SCO: model[rd_r] = word_t'((int'(vs) + int'(vt)) >= (1 << `CORE_DATA_W));
			default: return 1'b0;
		endcase
		return 1'b1;
	endfunction

	// One APB transfer with outputs sampled a quarter period after the falling edge
	task automatic apb_transfer(input logic write, input logic [`CORE_APB_ADDR_W-1:0] addr,
			input word_t wdata, output word_t rdata, output logic err);
		int waited;
		@(negedge clk);
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = write;
		apb_req.paddr = addr;
		apb_req.pwdata = wdata;
		// Slave stays quiet during setup
		#(CLK_PERIOD/4);
		check_err("pready in setup phase", apb_rsp.pready, 1'b0);
		check_err("pslverr in setup phase", apb_rsp.pslverr, 1'b0);
		@(negedge clk);
		apb_req.penable = 1'b1;
		waited = 0;
		#(CLK_PERIOD/4);
		// Writes finish with zero wait states
		if (write) begin
			check_err("pready on write access", apb_rsp.pready, 1'b1);
		end
		while (!apb_rsp.pready && waited < WAIT_LIMIT) begin
			@(negedge clk);
			#(CLK_PERIOD/4);
			waited++;
		end
		if (!apb_rsp.pready) begin
			$display("Timeout: pready stayed low for %0d cycles at address %h", waited, addr);
			$display("Some tests failed");
			$finish;
		end else begin
			rdata = apb_rsp.prdata;
			err = apb_rsp.pslverr;
			@(posedge clk);
		end
	endtask

	task automatic apb_write(input logic [`CORE_APB_ADDR_W-1:0] addr, input word_t data,
			output logic err);
		word_t unused;
		apb_transfer(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [`CORE_APB_ADDR_W-1:0] addr, output word_t data,
			output logic err);
		apb_transfer(1'b0, addr, '0, data, err);
	endtask

	task automatic bus_idle();
		@(negedge clk);
		apb_req = '0;
	endtask

	task automatic issue(input word_t instr);
		logic legal;
		logic err;
		legal = model_exec(instr);
		apb_write(`CORE_ADDR_INSTR, instr, err);
		check_err($sformatf("pslverr for instruction %h", instr), err, ~legal);
	endtask

	task automatic check_regs();
		word_t data;
		logic  err;
		for (int r = 0; r < `CORE_REG_CNT; r++) begin
			apb_read(reg_addr(r), data, err);
			check_word($sformatf("r%0d", r), data, model[r]);
			check_err($sformatf("pslverr on r%0d read", r), err, 1'b0);
		end
	endtask

	task automatic test_byte_loads();
		word_t v;
		for (int r = 0; r < `CORE_REG_CNT; r++) begin
			v = word_t'($random(seed));
			issue(enc_b(OP_LBI, reg_idx_t'(r), v[15:8]));
			issue(enc_b(OP_SLBI, reg_idx_t'(r), v[7:0]));
		end
		check_regs();
	endtask

	task automatic test_immediates();
		logic [4:0] ops [8] = '{OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI,
			OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI};
		word_t      rnd;
		for (int i = 0; i < 8; i++) begin
			for (int k = 0; k < 3; k++) begin
				rnd = word_t'($random(seed));
				issue(enc_i(ops[i], rnd[2:0], rnd[5:3], rnd[10:6]));
			end
			check_regs();
		end
	endtask

	// Each instruction reads the previous destination, so forwarding is hit
	task automatic test_dependent_chain();
		logic [4:0] ops [7] = '{OP_ALU_R, OP_SHIFT_R, OP_SEQ, OP_SLT, OP_SLE, OP_SCO, OP_BTR};
		word_t      rnd;
		reg_idx_t   prev_rd;
		prev_rd = 3'd0;
		for (int i = 0; i < 24; i++) begin
			rnd = word_t'($random(seed));
			issue(enc_r(ops[rnd[15:8] % 7], prev_rd, rnd[2:0], rnd[5:3], rnd[7:6]));
			prev_rd = rnd[5:3];
		end
		check_regs();
	endtask

	task automatic test_error_responses();
		logic [4:0] bad [5] = '{5'b00000, 5'b00111, 5'b01100, 5'b10001, 5'b10011};
		word_t      data;
		logic       err;
		for (int i = 0; i < 5; i++) begin
			issue(enc_i(bad[i], reg_idx_t'(i), reg_idx_t'(i + 1), 5'h1f));
		end
		apb_read(`CORE_ADDR_INSTR, data, err);
		check_err("pslverr on instruction address read", err, 1'b1);
		check_word("prdata on instruction address read", data, '0);
		apb_write(reg_addr(3), word_t'($random(seed)), err);
		check_err("pslverr on register address write", err, 1'b1);
		apb_write(8'h04, word_t'($random(seed)), err);
		check_err("pslverr on unmapped write", err, 1'b1);
		check_regs();
	endtask

	task automatic test_read_after_write();
		word_t    rnd;
		word_t    data;
		logic     err;
		reg_idx_t rd;
		for (int i = 0; i < 4; i++) begin
			rnd = word_t'($random(seed));
			rd = rnd[2:0];
			issue(enc_i(OP_ADDI, rnd[5:3], rd, rnd[10:6]));
			apb_read(reg_addr(rd), data, err);
			check_word($sformatf("r%0d right after write", rd), data, model[rd]);
			check_err("pslverr on read after write", err, 1'b0);
		end
	endtask

	initial begin
		seed = 32'hafc02586;
		errors = 0;
		checks = 0;
		rst_n = 1'b0;
		apb_req = '0;
		for (int r = 0; r < `CORE_REG_CNT; r++) begin
			model[r] = '0;
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		check_regs();
		test_byte_loads();
		test_immediates();
		test_dependent_chain();
		test_error_responses();
		test_read_after_write();
		bus_idle();

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule
